//--- hdl/mips_pkg.sv
`default_nettype none

package mips_pkg;

	typedef logic [31:0] word_t;		// data or address word.
	typedef logic [4:0]  reg_addr_t;	// general register number.

	// primary opcodes, instr[31:26].
	localparam logic [5:0] OP_SPECIAL = 6'b000000;
	localparam logic [5:0] OP_ADDIU   = 6'b001001;
	localparam logic [5:0] OP_ORI     = 6'b001101;
	localparam logic [5:0] OP_LUI     = 6'b001111;
	localparam logic [5:0] OP_LW      = 6'b100011;
	localparam logic [5:0] OP_LB      = 6'b100000;
	localparam logic [5:0] OP_SW      = 6'b101011;
	localparam logic [5:0] OP_SB      = 6'b101000;
	localparam logic [5:0] OP_BEQ     = 6'b000100;
	localparam logic [5:0] OP_BNE     = 6'b000101;

	// function codes of the special opcode, instr[5:0].
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_SLT  = 6'b101010;
	localparam logic [5:0] FN_SLL  = 6'b000000;
	localparam logic [5:0] FN_SRL  = 6'b000010;

	// nop must stay at zero so that a cleared stage register is idle.
	typedef enum logic [3:0] {
		ALU_NOP = 4'd0,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_LUI,
		ALU_LW,
		ALU_LB,
		ALU_SW,
		ALU_SB
	} alu_op_e;

	typedef struct packed {
		logic      we;		// write enable.
		reg_addr_t addr;	// destination register.
		word_t     data;	// value to write.
	} wb_req_t;

	typedef struct packed {
		word_t pc;			// fetch address.
		word_t inst;		// instruction word.
	} if_id_t;

	typedef struct packed {
		alu_op_e   op;
		word_t     a;				// operand a, or shift amount.
		word_t     b;				// operand b or immediate.
		word_t     store_data;		// rt value for stores.
		logic      we;
		reg_addr_t dst;
	} id_ex_t;

	typedef struct packed {
		alu_op_e op;
		word_t   addr;			// effective address for loads and stores.
		word_t   store_data;
		wb_req_t wb;
	} ex_mem_t;

	typedef wb_req_t mem_wb_t;

endpackage

`default_nettype wire

//--- hdl/rf_read_if.sv
`timescale 1ns/10ps
`default_nettype none

interface rf_read_if import mips_pkg::*; ();

	logic      re1;
	reg_addr_t addr1;
	word_t     data1;
	logic      re2;
	reg_addr_t addr2;
	word_t     data2;

	modport dec (output re1, addr1, re2, addr2, input data1, data2);	// decode side.
	modport rf (input re1, addr1, re2, addr2, output data1, data2);		// register file side.

endinterface

`default_nettype wire

//--- hdl/pc_reg.sv
`timescale 1ns/10ps
`default_nettype none

module pc_reg import mips_pkg::*; #(
	parameter word_t RESET_PC = 32'h0000_0000
) (
	input  wire        clk,
	input  wire        reset_i,
	input  wire        stall_i,
	input  wire        branch_taken_i,
	input  wire word_t branch_target_i,
	output word_t      pc_o,
	output logic       ce_o
);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			ce_o <= 1'b0;
			pc_o <= RESET_PC;
		end else if (!ce_o) begin
			ce_o <= 1'b1;			// first fetch comes from the reset vector.
			pc_o <= RESET_PC;
		end else if (stall_i) begin
			pc_o <= pc_o;			// load-use hazard, fetch again.
		end else if (branch_taken_i) begin
			pc_o <= branch_target_i;
		end else begin
			pc_o <= pc_o + 32'd4;
		end
	end

endmodule

`default_nettype wire

//--- hdl/pipe_reg.sv
`timescale 1ns/10ps
`default_nettype none

module pipe_reg #(
	parameter type payload_t = logic [31:0]
) (
	input  wire           clk,
	input  wire           reset_i,
	input  wire           hold_i,
	input  wire           bubble_i,
	input  wire payload_t d_i,
	output payload_t      q_o
);

	// an all-zero payload is a nop that writes nothing and touches no memory.
	always_ff @(posedge clk) begin
		if (reset_i || bubble_i) begin
			q_o <= '0;
		end else if (!hold_i) begin
			q_o <= d_i;
		end
	end

endmodule

`default_nettype wire

//--- hdl/regfile.sv
`timescale 1ns/10ps
`default_nettype none

module regfile import mips_pkg::*; (
	input  wire          clk,
	input  wire          reset_i,
	input  wire wb_req_t wb_i,
	rf_read_if.rf        rd
);

	word_t regs [1:31];		// register zero is not stored.

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_i.we && wb_i.addr != 5'd0) begin
			regs[wb_i.addr] <= wb_i.data;
		end
	end

	// write-through, so decode sees a result in the same cycle it is written.
	function automatic word_t read_port(input logic re, input reg_addr_t ra);
		if (!re || ra == 5'd0) begin
			return '0;
		end
		if (wb_i.we && wb_i.addr == ra) begin
			return wb_i.data;
		end
		return regs[ra];
	endfunction

	always_comb begin
		rd.data1 = read_port(rd.re1, rd.addr1);
		rd.data2 = read_port(rd.re2, rd.addr2);
	end

endmodule

`default_nettype wire

//--- hdl/decoder.sv
`timescale 1ns/10ps
`default_nettype none

module decoder import mips_pkg::*; (
	input  wire if_id_t  if_id_i,
	rf_read_if.dec       rf,
	input  wire wb_req_t ex_fwd_i,
	input  wire          ex_is_load_i,
	input  wire wb_req_t mem_fwd_i,
	output id_ex_t       id_ex_o,
	output logic         stall_o,
	output logic         branch_taken_o,
	output word_t        branch_target_o
);

	logic [5:0]  opcode;
	logic [5:0]  funct;
	reg_addr_t   rs;
	reg_addr_t   rt;
	reg_addr_t   rd;
	logic [4:0]  sa;
	logic [15:0] imm;

	alu_op_e     dec_op;
	logic        wr_en;
	reg_addr_t   dst;
	logic        use_imm;		// operand b comes from the immediate.
	logic        use_sa;		// operand a is the shift amount.
	word_t       imm_val;
	logic        is_beq;
	logic        is_bne;
	word_t       src1;
	word_t       src2;

	assign opcode = if_id_i.inst[31:26];
	assign rs     = if_id_i.inst[25:21];
	assign rt     = if_id_i.inst[20:16];
	assign rd     = if_id_i.inst[15:11];
	assign sa     = if_id_i.inst[10:6];
	assign funct  = if_id_i.inst[5:0];
	assign imm    = if_id_i.inst[15:0];

	always_comb begin
		rf.re1  = 1'b0;
		rf.re2  = 1'b0;
		rf.addr1 = rs;
		rf.addr2 = rt;
		dec_op  = ALU_NOP;
		wr_en   = 1'b0;
		dst     = rt;
		use_imm = 1'b1;
		use_sa  = 1'b0;
		imm_val = {{16{imm[15]}}, imm};		// sign extended by default.
		is_beq  = 1'b0;
		is_bne  = 1'b0;
		case (opcode)
			OP_SPECIAL: begin
				dst     = rd;
				use_imm = 1'b0;
				rf.re2  = 1'b1;
				rf.re1  = 1'b1;
				wr_en   = 1'b1;
				case (funct)
					FN_ADDU: dec_op = ALU_ADD;
					FN_SUBU: dec_op = ALU_SUB;
					FN_AND:  dec_op = ALU_AND;
					FN_OR:   dec_op = ALU_OR;
					FN_XOR:  dec_op = ALU_XOR;
					FN_SLT:  dec_op = ALU_SLT;
					FN_SLL: begin
						dec_op = ALU_SLL;
						use_sa = 1'b1;
						rf.re1 = 1'b0;		// shifts read rt only.
					end
					FN_SRL: begin
						dec_op = ALU_SRL;
						use_sa = 1'b1;
						rf.re1 = 1'b0;
					end
					default: begin
						rf.re1 = 1'b0;
						rf.re2 = 1'b0;
						wr_en  = 1'b0;
					end
				endcase
			end
			OP_ADDIU: begin
				dec_op = ALU_ADD;
				rf.re1 = 1'b1;
				wr_en  = 1'b1;
			end
			OP_ORI: begin
				dec_op  = ALU_OR;
				rf.re1  = 1'b1;
				wr_en   = 1'b1;
				imm_val = {16'h0000, imm};	// zero extended.
			end
			OP_LUI: begin
				dec_op  = ALU_LUI;
				wr_en   = 1'b1;
				imm_val = {imm, 16'h0000};
			end
			OP_LW, OP_LB: begin
				dec_op = (opcode == OP_LW) ? ALU_LW : ALU_LB;
				rf.re1 = 1'b1;
				wr_en  = 1'b1;
			end
			OP_SW, OP_SB: begin
				dec_op = (opcode == OP_SW) ? ALU_SW : ALU_SB;
				rf.re1 = 1'b1;
				rf.re2 = 1'b1;			// store data.
			end
			OP_BEQ, OP_BNE: begin
				rf.re1 = 1'b1;
				rf.re2 = 1'b1;
				is_beq = (opcode == OP_BEQ);
				is_bne = (opcode == OP_BNE);
			end
			default: ;					// unknown opcode stays a nop.
		endcase
	end

	// newest value wins: execute, then memory, then the register file.
	function automatic word_t pick(input logic re, input reg_addr_t ra, input word_t rf_val);
		if (!re) begin
			return '0;
		end
		if (ex_fwd_i.we && ex_fwd_i.addr == ra) begin
			return ex_fwd_i.data;
		end
		if (mem_fwd_i.we && mem_fwd_i.addr == ra) begin
			return mem_fwd_i.data;
		end
		return rf_val;
	endfunction

	assign src1 = pick(rf.re1, rs, rf.data1);
	assign src2 = pick(rf.re2, rt, rf.data2);

	// load in execute whose result is needed here.
	assign stall_o = ex_is_load_i &&
		((rf.re1 && ex_fwd_i.addr == rs) || (rf.re2 && ex_fwd_i.addr == rt));

	always_comb begin
		id_ex_o.op         = dec_op;
		id_ex_o.a          = use_sa ? {27'd0, sa} : src1;
		id_ex_o.b          = use_imm ? imm_val : src2;
		id_ex_o.store_data = src2;
		id_ex_o.we         = wr_en && (dst != 5'd0);
		id_ex_o.dst        = dst;
	end

	// target is relative to the delay slot.
	assign branch_target_o = if_id_i.pc + 32'd4 + {{14{imm[15]}}, imm, 2'b00};
	assign branch_taken_o  = !stall_o &&
		((is_beq && src1 == src2) || (is_bne && src1 != src2));

endmodule

`default_nettype wire

//--- hdl/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu import mips_pkg::*; (
	input  wire id_ex_t id_ex_i,
	output ex_mem_t     ex_mem_o,
	output wb_req_t     fwd_o,
	output logic        is_load_o
);

	word_t sum;
	word_t result;
	logic  load;

	assign sum = id_ex_i.a + id_ex_i.b;		// also the memory address.

	always_comb begin
		case (id_ex_i.op)
			ALU_ADD: result = sum;
			ALU_SUB: result = id_ex_i.a - id_ex_i.b;
			ALU_AND: result = id_ex_i.a & id_ex_i.b;
			ALU_OR:  result = id_ex_i.a | id_ex_i.b;
			ALU_XOR: result = id_ex_i.a ^ id_ex_i.b;
			ALU_SLT: result = {31'd0, $signed(id_ex_i.a) < $signed(id_ex_i.b)};
			ALU_SLL: result = id_ex_i.b << id_ex_i.a[4:0];
			ALU_SRL: result = id_ex_i.b >> id_ex_i.a[4:0];
			ALU_LUI: result = id_ex_i.b;
			default: result = '0;				// loads fill in data in memory stage.
		endcase
	end

	assign load = (id_ex_i.op == ALU_LW) || (id_ex_i.op == ALU_LB);

	always_comb begin
		ex_mem_o.op         = id_ex_i.op;
		ex_mem_o.addr       = sum;
		ex_mem_o.store_data = id_ex_i.store_data;
		ex_mem_o.wb.we      = id_ex_i.we;
		ex_mem_o.wb.addr    = id_ex_i.dst;
		ex_mem_o.wb.data    = result;
	end

	// load data is not ready yet, decode stalls instead of forwarding.
	always_comb begin
		fwd_o    = ex_mem_o.wb;
		fwd_o.we = id_ex_i.we && !load;
	end

	assign is_load_o = id_ex_i.we && load;

endmodule

`default_nettype wire

//--- hdl/mem_stage.sv
`timescale 1ns/10ps
`default_nettype none

module mem_stage import mips_pkg::*; (
	input  wire ex_mem_t ex_mem_i,
	input  wire word_t   ram_data_i,
	output word_t        ram_addr_o,
	output word_t        ram_data_o,
	output logic         ram_we_o,
	output logic [3:0]   ram_sel_o,
	output logic         ram_ce_o,
	output mem_wb_t      mem_wb_o,
	output wb_req_t      fwd_o
);

	logic [3:0] lane;
	logic [7:0] ld_byte;

	assign lane = 4'b1000 >> ex_mem_i.addr[1:0];	// big endian, offset 0 is msb lane.
	assign ram_addr_o = {ex_mem_i.addr[31:2], 2'b00};

	always_comb begin
		ram_ce_o   = 1'b0;
		ram_we_o   = 1'b0;
		ram_sel_o  = 4'b0000;
		ram_data_o = '0;
		case (ex_mem_i.op)
			ALU_LW: begin
				ram_ce_o  = 1'b1;
				ram_sel_o = 4'b1111;
			end
			ALU_LB: begin
				ram_ce_o  = 1'b1;
				ram_sel_o = lane;
			end
			ALU_SW: begin
				ram_ce_o   = 1'b1;
				ram_we_o   = 1'b1;
				ram_sel_o  = 4'b1111;
				ram_data_o = ex_mem_i.store_data;
			end
			ALU_SB: begin
				ram_ce_o   = 1'b1;
				ram_we_o   = 1'b1;
				ram_sel_o  = lane;
				ram_data_o = {4{ex_mem_i.store_data[7:0]}};	// byte on every lane.
			end
			default: ;
		endcase
	end

	always_comb begin
		case (ex_mem_i.addr[1:0])
			2'd0:    ld_byte = ram_data_i[31:24];
			2'd1:    ld_byte = ram_data_i[23:16];
			2'd2:    ld_byte = ram_data_i[15:8];
			default: ld_byte = ram_data_i[7:0];
		endcase
	end

	always_comb begin
		mem_wb_o = ex_mem_i.wb;
		if (ex_mem_i.op == ALU_LW) begin
			mem_wb_o.data = ram_data_i;
		end else if (ex_mem_i.op == ALU_LB) begin
			mem_wb_o.data = {{24{ld_byte[7]}}, ld_byte};	// sign extended.
		end
	end

	assign fwd_o = mem_wb_o;

endmodule

`default_nettype wire

//--- hdl/mips_core.sv
`timescale 1ns/10ps
`default_nettype none

module mips_core import mips_pkg::*; #(
	parameter word_t RESET_PC = 32'h0000_0000
) (
	input  wire        clk,
	input  wire        reset_i,
	input  wire word_t rom_data_i,
	output word_t      rom_addr_o,
	output logic       rom_ce_o,
	input  wire word_t ram_data_i,
	output word_t      ram_addr_o,
	output word_t      ram_data_o,
	output logic       ram_we_o,
	output logic [3:0] ram_sel_o,
	output logic       ram_ce_o
);

	if_id_t  id_in;			// fetch-decode register output.
	id_ex_t  id_out;
	id_ex_t  ex_in;
	ex_mem_t ex_out;
	ex_mem_t mem_in;
	mem_wb_t mem_out;
	mem_wb_t wb_req;		// write request into the register file.

	wb_req_t ex_fwd;
	wb_req_t mem_fwd;
	logic    ex_is_load;
	logic    stall;
	logic    branch_taken;
	word_t   branch_target;

	rf_read_if rf_bus ();

	pc_reg #(.RESET_PC(RESET_PC)) pc_reg0 (
		.clk            (clk),
		.reset_i        (reset_i),
		.stall_i        (stall),
		.branch_taken_i (branch_taken),
		.branch_target_i(branch_target),
		.pc_o           (rom_addr_o),
		.ce_o           (rom_ce_o)
	);

	// nothing valid is fetched until chip enable rises.
	pipe_reg #(.payload_t(if_id_t)) if_id0 (
		.clk     (clk),
		.reset_i (reset_i),
		.hold_i  (stall),
		.bubble_i(!rom_ce_o),
		.d_i     ({rom_addr_o, rom_data_i}),
		.q_o     (id_in)
	);

	decoder decoder0 (
		.if_id_i        (id_in),
		.rf             (rf_bus.dec),
		.ex_fwd_i       (ex_fwd),
		.ex_is_load_i   (ex_is_load),
		.mem_fwd_i      (mem_fwd),
		.id_ex_o        (id_out),
		.stall_o        (stall),
		.branch_taken_o (branch_taken),
		.branch_target_o(branch_target)
	);

	regfile regfile0 (
		.clk    (clk),
		.reset_i(reset_i),
		.wb_i   (wb_req),
		.rd     (rf_bus.rf)
	);

	pipe_reg #(.payload_t(id_ex_t)) id_ex0 (
		.clk     (clk),
		.reset_i (reset_i),
		.hold_i  (1'b0),
		.bubble_i(stall),		// load-use bubble.
		.d_i     (id_out),
		.q_o     (ex_in)
	);

	alu alu0 (
		.id_ex_i  (ex_in),
		.ex_mem_o (ex_out),
		.fwd_o    (ex_fwd),
		.is_load_o(ex_is_load)
	);

	pipe_reg #(.payload_t(ex_mem_t)) ex_mem0 (
		.clk     (clk),
		.reset_i (reset_i),
		.hold_i  (1'b0),
		.bubble_i(1'b0),
		.d_i     (ex_out),
		.q_o     (mem_in)
	);

	mem_stage mem_stage0 (
		.ex_mem_i  (mem_in),
		.ram_data_i(ram_data_i),
		.ram_addr_o(ram_addr_o),
		.ram_data_o(ram_data_o),
		.ram_we_o  (ram_we_o),
		.ram_sel_o (ram_sel_o),
		.ram_ce_o  (ram_ce_o),
		.mem_wb_o  (mem_out),
		.fwd_o     (mem_fwd)
	);

	pipe_reg #(.payload_t(mem_wb_t)) mem_wb0 (
		.clk     (clk),
		.reset_i (reset_i),
		.hold_i  (1'b0),
		.bubble_i(1'b0),
		.d_i     (mem_out),
		.q_o     (wb_req)
	);

endmodule

`default_nettype wire

//--- testbench/mips_core_sva.sv
`timescale 1ns/10ps
`default_nettype none

module mips_core_sva import mips_pkg::*; #(
	parameter word_t RESET_PC = 32'h0000_0000
) (
	input  wire        clk,
	input  wire        reset_i,
	input  wire word_t rom_addr_o,
	input  wire        rom_ce_o,
	input  wire word_t ram_data_o,
	input  wire        ram_we_o,
	input  wire [3:0]  ram_sel_o,
	input  wire        ram_ce_o
);

	// both memories stay idle while reset is held.
	reset_idle: assert property (@(posedge clk)
		reset_i |=> (!rom_ce_o && !ram_ce_o && !ram_we_o))
		else $error("memory ports active during reset");

	first_fetch: assert property (@(posedge clk)
		$fell(reset_i) |=> (rom_ce_o && rom_addr_o == RESET_PC))
		else $error("first fetch is not at the reset vector");

	// a load-use stall repeats a fetch address once, never twice.
	single_hold: assert property (@(posedge clk) disable iff (reset_i)
		rom_ce_o && $past(rom_ce_o) && $stable(rom_addr_o) |=> !$stable(rom_addr_o))
		else $error("fetch address held for more than two cycles");

	fetch_aligned: assert property (@(posedge clk) disable iff (reset_i)
		rom_ce_o |-> rom_addr_o[1:0] == 2'b00)
		else $error("fetch address not word aligned");

	write_lanes: assert property (@(posedge clk) disable iff (reset_i)
		ram_we_o |-> ram_ce_o && (ram_sel_o == 4'b1111 || $onehot(ram_sel_o)))
		else $error("write with a bad byte select");

	byte_replicated: assert property (@(posedge clk) disable iff (reset_i)
		ram_we_o && ram_sel_o != 4'b1111 |-> ram_data_o == {4{ram_data_o[7:0]}})
		else $error("byte store data not on all lanes");

endmodule

bind mips_core mips_core_sva #(.RESET_PC(RESET_PC)) sva0 (
	.clk       (clk),
	.reset_i   (reset_i),
	.rom_addr_o(rom_addr_o),
	.rom_ce_o  (rom_ce_o),
	.ram_data_o(ram_data_o),
	.ram_we_o  (ram_we_o),
	.ram_sel_o (ram_sel_o),
	.ram_ce_o  (ram_ce_o)
);

`default_nettype wire

//--- testbench/tb_mips_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mips_core import mips_pkg::*; ();

	localparam word_t MARKER_ADDR    = 32'h0000_07f0;	// last store of the program.
	localparam int    TIMEOUT_CYCLES = 2000;

	logic       clk;
	logic       reset_i;
	word_t      rom_addr_o;
	logic       rom_ce_o;
	word_t      rom_data_i;
	word_t      ram_addr_o;
	word_t      ram_data_o;
	word_t      ram_data_i;
	logic       ram_we_o;
	logic [3:0] ram_sel_o;
	logic       ram_ce_o;

	word_t      rom [0:255];
	word_t      ram [0:511];
	word_t      ref_r [0:31];		// register values of the reference model.
	int         pc_n = 0;			// next rom word to fill.
	word_t      rnd = 32'h34853301;
	word_t      exp_data [word_t];	// expected stores, keyed by word address.
	logic [3:0] exp_sel [word_t];
	bit         exp_hit [word_t];
	word_t      exp_addrs [$];
	word_t      br_pc [$];			// taken branches and their targets.
	word_t      br_tgt [$];
	word_t      hold_addr = '1;
	word_t      prev1 = '1;
	word_t      prev2 = '1;
	int         hold_cnt = 0;
	int         br_checked = 0;
	int         checks = 0;
	int         errors = 0;
	bit         done = 1'b0;
	bit         ended = 1'b0;

	mips_core #(.RESET_PC(32'h0000_0000)) dut (
		.clk       (clk),
		.reset_i   (reset_i),
		.rom_data_i(rom_data_i),
		.rom_addr_o(rom_addr_o),
		.rom_ce_o  (rom_ce_o),
		.ram_data_i(ram_data_i),
		.ram_addr_o(ram_addr_o),
		.ram_data_o(ram_data_o),
		.ram_we_o  (ram_we_o),
		.ram_sel_o (ram_sel_o),
		.ram_ce_o  (ram_ce_o)
	);

	assign rom_data_i = rom[rom_addr_o[9:2]];	// both memories answer in the same cycle.
	assign ram_data_i = ram[ram_addr_o[10:2]];

	always @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < 512; i++) begin
				ram[i] <= 32'h5a5a_0000 ^ word_t'(i * 4);	// depends on the full byte address.
			end
		end else if (ram_ce_o && ram_we_o) begin
			for (int l = 0; l < 4; l++) begin
				if (ram_sel_o[l]) begin
					ram[ram_addr_o[10:2]][l*8 +: 8] <= ram_data_o[l*8 +: 8];
				end
			end
		end
	end

	function automatic word_t xorshift(input word_t x);
		word_t y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic word_t next_rand();
		rnd = xorshift(rnd);
		return rnd;
	endfunction

	function automatic word_t r_type(input reg_addr_t rs, input reg_addr_t rt,
			input reg_addr_t rd, input logic [4:0] sa, input logic [5:0] fn);
		return {OP_SPECIAL, rs, rt, rd, sa, fn};
	endfunction

	function automatic word_t i_type(input logic [5:0] op, input reg_addr_t rs,
			input reg_addr_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// expected result of an R-type operation.
	function automatic word_t alu_model(input logic [5:0] fn, input word_t a, input word_t b,
			input logic [4:0] sa);
		case (fn)
			FN_ADDU: return a + b;
			FN_SUBU: return a - b;
			FN_AND:  return a & b;
			FN_OR:   return a | b;
			FN_XOR:  return a ^ b;
			FN_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			FN_SLL:  return b << sa;
			default: return b >> sa;
		endcase
	endfunction

	task automatic emit(input word_t w);
		rom[pc_n] = w;
		pc_n++;
	endtask

	task automatic expect_store(input word_t addr, input word_t data, input logic [3:0] sel);
		exp_data[addr] = data;
		exp_sel[addr]  = sel;
		exp_hit[addr]  = 1'b0;
		exp_addrs.push_back(addr);
	endtask

	task automatic check(input bit ok, input string msg);
		checks++;
		assert (ok) else begin
			errors++;
			$display("CHECK FAILED at %0t: %s", $time, msg);
		end
	endtask

	task automatic build_program();
		logic [5:0] fns [0:7];
		word_t      v;
		word_t      ea;
		word_t      bpc;
		logic [4:0] sa;
		logic [15:0] imm;
		logic [7:0] bv;
		logic [3:0] sel;
		reg_addr_t  d;
		reg_addr_t  s1;
		reg_addr_t  s2;
		int         bo;
		fns = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLL, FN_SRL, FN_SLT};
		for (int i = 0; i < 256; i++) begin
			rom[i] = '0;						// sll r0, r0, 0 is a nop.
		end
		for (int i = 0; i < 32; i++) begin
			ref_r[i] = '0;
		end
		for (int r = 1; r <= 4; r++) begin
			v = next_rand();
			if (r == 1) begin
				v[0] = 1'b1;					// r1 nonzero for the bne.
			end
			emit(i_type(OP_LUI, 5'd0, reg_addr_t'(r), v[31:16]));
			emit(i_type(OP_ORI, reg_addr_t'(r), reg_addr_t'(r), v[15:0]));
			ref_r[r] = v;
		end
		// chain, each op reads the last two results.
		for (int k = 0; k < 9; k++) begin
			v  = next_rand();
			sa = v[4:0];
			d  = reg_addr_t'(5 + k);
			s1 = reg_addr_t'(4 + k);
			s2 = reg_addr_t'(3 + k);
			if (k == 8) begin
				imm = v[20:5];
				emit(i_type(OP_ADDIU, s1, d, imm));
				ref_r[d] = ref_r[s1] + {{16{imm[15]}}, imm};
			end else if (fns[k] == FN_SLL || fns[k] == FN_SRL) begin
				emit(r_type(5'd0, s1, d, sa, fns[k]));
				ref_r[d] = alu_model(fns[k], 32'd0, ref_r[s1], sa);
			end else begin
				emit(r_type(s1, s2, d, 5'd0, fns[k]));
				ref_r[d] = alu_model(fns[k], ref_r[s1], ref_r[s2], 5'd0);
			end
		end
		for (int k = 8; k >= 0; k--) begin
			ea = 32'h100 + word_t'(4 * k);
			emit(i_type(OP_SW, 5'd0, reg_addr_t'(5 + k), ea[15:0]));
			expect_store(ea, ref_r[5 + k], 4'hf);
		end
		// load-use, the fetch after the addu repeats once.
		emit(i_type(OP_LW, 5'd0, 5'd20, 16'h0100));
		hold_addr = word_t'((pc_n + 1) * 4);
		emit(r_type(5'd20, 5'd1, 5'd21, 5'd0, FN_ADDU));
		ref_r[21] = ref_r[5] + ref_r[1];
		emit(i_type(OP_SW, 5'd0, 5'd21, 16'h0200));
		expect_store(32'h200, ref_r[21], 4'hf);
		v = next_rand() | 32'h8080_8080;		// every byte negative.
		emit(i_type(OP_LUI, 5'd0, 5'd22, v[31:16]));
		emit(i_type(OP_ORI, 5'd22, 5'd22, v[15:0]));
		emit(i_type(OP_SW, 5'd0, 5'd22, 16'h0300));
		expect_store(32'h300, v, 4'hf);
		bo = int'(next_rand() % 4);
		ea = 32'h300 + word_t'(bo);
		emit(i_type(OP_LB, 5'd0, 5'd23, ea[15:0]));
		bv = v[(3 - bo)*8 +: 8];				// offset 0 is the top byte.
		ref_r[23] = {{24{bv[7]}}, bv};
		emit(i_type(OP_SW, 5'd0, 5'd23, 16'h0304));
		expect_store(32'h304, ref_r[23], 4'hf);
		for (int l = 0; l < 4; l++) begin
			ea  = 32'h320 + word_t'(l * 5);		// word 0x320 + 4l, byte offset l.
			bv  = ref_r[1 + l][7:0];
			sel = 4'b0000;
			sel[3 - l] = 1'b1;
			emit(i_type(OP_SB, 5'd0, reg_addr_t'(1 + l), ea[15:0]));
			expect_store(ea & ~32'h3, {4{bv}}, sel);
		end
		// taken beq, then taken bne, each skips one store.
		for (int b = 0; b < 2; b++) begin
			bpc = word_t'(pc_n * 4);
			emit(i_type((b == 0) ? OP_BEQ : OP_BNE, 5'd1, (b == 0) ? 5'd1 : 5'd0, 16'd2));
			br_pc.push_back(bpc);
			br_tgt.push_back(bpc + 32'd4 + (32'd2 << 2));
			ea = 32'h400 + word_t'(8 * b);
			emit(i_type(OP_SW, 5'd0, 5'd1, ea[15:0]));
			expect_store(ea, ref_r[1], 4'hf);
			ea = ea + 32'd4;
			emit(i_type(OP_SW, 5'd0, 5'd1, ea[15:0]));
		end
		emit(i_type(OP_BEQ, 5'd1, 5'd0, 16'd2));	// not taken.
		emit(i_type(OP_SW, 5'd0, 5'd1, 16'h0410));
		expect_store(32'h410, ref_r[1], 4'hf);
		emit(i_type(OP_SW, 5'd0, 5'd1, 16'h0414));
		expect_store(32'h414, ref_r[1], 4'hf);
		emit(i_type(OP_SW, 5'd0, 5'd1, MARKER_ADDR[15:0]));
		expect_store(MARKER_ADDR, ref_r[1], 4'hf);
		emit(i_type(OP_BEQ, 5'd0, 5'd0, 16'hffff));	// spin here, slot is a nop.
	endtask

	// outputs are stable at the falling edge.
	always @(negedge clk) begin
		if (!reset_i && ram_ce_o && ram_we_o) begin
			assert (exp_data.exists(ram_addr_o)) else begin
				errors++;
				$display("store to address %h, which the program should never reach",
					ram_addr_o);
			end
			if (exp_data.exists(ram_addr_o)) begin
				check(ram_data_o == exp_data[ram_addr_o], $sformatf(
					"store data at %h is %h, expected %h",
					ram_addr_o, ram_data_o, exp_data[ram_addr_o]));
				check(ram_sel_o == exp_sel[ram_addr_o], $sformatf(
					"byte select at %h is %b, expected %b",
					ram_addr_o, ram_sel_o, exp_sel[ram_addr_o]));
				exp_hit[ram_addr_o] = 1'b1;
			end
			if (ram_addr_o == MARKER_ADDR) begin
				done = 1'b1;
			end
		end
		if (!reset_i && rom_ce_o) begin
			if (rom_addr_o == hold_addr) begin
				hold_cnt++;
			end
			for (int i = 0; i < br_pc.size(); i++) begin
				if (prev2 == br_pc[i]) begin
					check(rom_addr_o == br_tgt[i], $sformatf(
						"fetch after branch at %h is %h, expected %h",
						br_pc[i], rom_addr_o, br_tgt[i]));
					br_checked++;
				end
			end
		end
		prev2 = prev1;
		prev1 = rom_ce_o ? rom_addr_o : 32'hffff_ffff;
	end

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		int cycles;
		reset_i = 1'b1;
		build_program();
		repeat (4) @(posedge clk);
		#1 reset_i = 1'b0;
		cycles = 0;
		while (!done && cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		if (!done) begin
			errors++;
			$display("timeout, no store to the marker address after %0d cycles", cycles);
		end else begin
			foreach (exp_addrs[i]) begin
				assert (exp_hit[exp_addrs[i]]) else begin
					errors++;
					$display("the store to address %h never happened", exp_addrs[i]);
				end
			end
			check(hold_cnt == 2, $sformatf(
				"fetch address held for %0d cycles at the load-use point, expected 2",
				hold_cnt));
			check(br_checked == 2, $sformatf(
				"%0d branch targets seen on the fetch address, expected 2", br_checked));
		end
		ended = 1'b1;
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	// the run stopped before the summary, e.g. on a failed concurrent assertion.
	final begin
		if (!ended) begin
			$display("=== FAIL ===");
		end
	end

endmodule

`default_nettype wire

//--- files.f
hdl/mips_pkg.sv
hdl/rf_read_if.sv
hdl/pc_reg.sv
hdl/pipe_reg.sv
hdl/regfile.sv
hdl/decoder.sv
hdl/alu.sv
hdl/mem_stage.sv
hdl/mips_core.sv
testbench/mips_core_sva.sv
testbench/tb_mips_core.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_mips_core
FILELIST  = files.f
MDIR      = obj_dir

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(MDIR)
	@out="$$(./$(MDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf $(MDIR)
